// ==== all.f ====
dga_cmd_pkg.sv
dga_idb_pkg.sv
mem_cmd_decode.sv
ctl_cmd_decode.sv
bus_req_ctrl.sv
dga_decode.sv
tb_dga_decode.sv

// ==== Bender.yml ====
package:
  name: dga_decode

sources:
  - dga_cmd_pkg.sv
  - dga_idb_pkg.sv
  - mem_cmd_decode.sv
  - ctl_cmd_decode.sv
  - bus_req_ctrl.sv
  - dga_decode.sv
  - target: test
    files:
      - tb_dga_decode.sv

// ==== tb_dga_decode.sv ====
// Directed-test testbench for the decode gate array command decoder
// Check task, one task per test, watchdog and closing summary

`timescale 1ns/1ns

module tb_dga_decode;

  import dga_cmd_pkg::*;
  import dga_idb_pkg::*;

  localparam int NUM_TESTS = 6;

  logic              clk;
  logic              rst_n;
  logic              lcs;
  logic [CODE_W-1:0] cscomm;
  logic [MOD_W-1:0]  csmis;
  logic [IDB_W-1:0]  idb;
  logic              hit_n;
  logic              lshadow;
  logic              brk_n;
  logic              eorf_n;
  logic              mreq;
  logic              fetch;
  logic              write;
  logic              start_n;
  logic              sstop_n;
  logic              clrti_n;
  logic              sioc_n;
  logic              wchim_n;
  logic              emcl_n;
  logic              reset;
  logic              ecreq;
  logic              lhit;
  logic              ldpanc_n;
  logic              empid_n;

  int   err_count;
  int   check_count;
  int   seed_ret;
  logic lhit_model;

  dga_decode u_dga_decode (.*);

  always #5 clk = ~clk;

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("FAIL t=%0t %s: expected %0h, got %0h", $time, msg, expected, actual);
    end
  endtask

  function automatic logic [MOD_W-1:0] rand_mod();
    logic [31:0] r;
    r = $urandom;
    return r[MOD_W-1:0];
  endfunction

  function automatic logic [IDB_W-1:0] rand_idb();
    logic [31:0] r;
    r = $urandom;
    return r[IDB_W-1:0];
  endfunction

  // {mreq, fetch, write} as the memory command rules give them
  function automatic logic [2:0] mem_expect(input logic [CODE_W-1:0] code);
    logic is_mem;
    is_mem = (code == CMD_FETCH) || (code == CMD_READ) || (code == CMD_WRITE);
    return {is_mem, code == CMD_FETCH, code == CMD_WRITE};
  endfunction

  task automatic next_cycle();
    @(negedge clk);
  endtask

  task automatic present(input logic [CODE_W-1:0] code, input logic [MOD_W-1:0] mod,
                         input logic [IDB_W-1:0] data);
    lcs    = 1'b1;
    cscomm = code;
    csmis  = mod;
    idb    = data;
  endtask

  // One command at cycle 0, returns at the falling edge after it with lcs low
  task automatic issue(input logic [CODE_W-1:0] code, input logic [MOD_W-1:0] mod,
                       input logic [IDB_W-1:0] data);
    present(code, mod, data);
    next_cycle();
    lcs = 1'b0;
  endtask

  task automatic check_quiet(input string msg);
    check_value({mreq, fetch, write, ecreq}, 4'h0, {msg, " memory/request"});
    check_value({start_n, sstop_n, clrti_n, sioc_n, wchim_n, ldpanc_n, empid_n}, 7'h7f,
                {msg, " strobes"});
  endtask

  task automatic report_test(input string name, input int start_errs);
    $display("test %-14s %s (%0d errors)", name,
             (err_count == start_errs) ? "passed" : "failed", err_count - start_errs);
  endtask

  task automatic test_reset_idle();
    int start_errs;
    logic [CODE_W-1:0] codes [11];
    start_errs = err_count;
    codes = '{CMD_FETCH, CMD_READ, CMD_WRITE, CMD_START, CMD_SSTOP, CMD_CLRTI, CMD_SIOC,
              CMD_RESET, CMD_EMPID, CMD_LDPANC, CMD_WCHIM};
    check_value({mreq, fetch, write, reset, ecreq, lhit}, 6'h00, "reset levels");
    check_value({start_n, sstop_n, clrti_n, sioc_n, wchim_n, emcl_n, ldpanc_n, empid_n},
                8'hff, "reset strobes");
    // Every command with lcs low, data and hit set so that any load would show
    hit_n = 1'b0;
    foreach (codes[i]) begin
      cscomm = codes[i];
      csmis  = (codes[i] == CMD_LDPANC) ? MOD_LDPANC : MOD_WCHIM;
      idb    = '1;
      next_cycle();
      check_quiet("lcs low");
      check_value({reset, lhit, emcl_n}, 3'b001, "lcs low flags");
    end
    next_cycle();
    check_quiet("lcs low bus stage");
    check_value({reset, lhit, emcl_n}, 3'b001, "lcs low flags bus stage");
    hit_n = 1'b1;
    report_test("reset_idle", start_errs);
  endtask

  task automatic test_mem_cmds();
    int start_errs;
    logic [CODE_W-1:0] codes [6];
    start_errs = err_count;
    codes = '{CMD_FETCH, CMD_READ, CMD_WRITE, 5'h10, 5'h1F, 5'h13};
    foreach (codes[i]) begin
      issue(codes[i], rand_mod(), rand_idb());
      check_value({mreq, fetch, write}, mem_expect(codes[i]),
                  $sformatf("mem code %0h", codes[i]));
      next_cycle();
      check_value({mreq, fetch, write}, 3'b000, "mem level one cycle");
    end
    // Back to back
    present(CMD_FETCH, rand_mod(), rand_idb());
    next_cycle();
    present(CMD_WRITE, rand_mod(), rand_idb());
    check_value({mreq, fetch, write}, 3'b110, "b2b fetch");
    next_cycle();
    present(CMD_READ, rand_mod(), rand_idb());
    check_value({mreq, fetch, write}, 3'b101, "b2b write");
    next_cycle();
    lcs = 1'b0;
    check_value({mreq, fetch, write}, 3'b100, "b2b read");
    next_cycle();
    check_value({mreq, fetch, write}, 3'b000, "b2b end");
    report_test("mem_cmds", start_errs);
  endtask

  // Strobe order {start_n, sstop_n, clrti_n, sioc_n, wchim_n}
  task automatic run_ctl(input logic [CODE_W-1:0] code, input logic [MOD_W-1:0] mod,
                         input logic eorf, input logic [4:0] exp_n,
                         input logic exp_ld, input logic exp_em);
    issue(code, mod, rand_idb());
    eorf_n = eorf;
    check_value({start_n, sstop_n, clrti_n, sioc_n, wchim_n}, exp_n,
                $sformatf("strobes code %0h mod %0b", code, mod));
    next_cycle();
    eorf_n = 1'b1;
    check_value({start_n, sstop_n, clrti_n, sioc_n, wchim_n}, 5'h1f, "strobes cleared");
    check_value(ldpanc_n, !exp_ld, $sformatf("ldpanc_n code %0h eorf_n %0b", code, eorf));
    check_value(empid_n, !exp_em, $sformatf("empid_n code %0h eorf_n %0b", code, eorf));
    next_cycle();
    check_quiet("after control command");
  endtask

  task automatic test_ctl_cmds();
    int start_errs;
    start_errs = err_count;
    run_ctl(CMD_START, rand_mod(), 1'b1, 5'b01111, 1'b0, 1'b0);
    run_ctl(CMD_SSTOP, rand_mod(), 1'b1, 5'b10111, 1'b0, 1'b0);
    run_ctl(CMD_CLRTI, rand_mod(), 1'b1, 5'b11011, 1'b0, 1'b0);
    run_ctl(CMD_SIOC, rand_mod(), 1'b1, 5'b11101, 1'b0, 1'b0);
    run_ctl(CMD_WCHIM, 2'b00, 1'b1, 5'b11110, 1'b0, 1'b0);
    run_ctl(CMD_RESET, rand_mod(), 1'b1, 5'b11111, 1'b0, 1'b0);
    // Wrong modifiers give nothing
    run_ctl(CMD_WCHIM, 2'b01, 1'b1, 5'b11111, 1'b0, 1'b0);
    run_ctl(CMD_WCHIM, 2'b10, 1'b1, 5'b11111, 1'b0, 1'b0);
    run_ctl(CMD_WCHIM, 2'b11, 1'b1, 5'b11111, 1'b0, 1'b0);
    run_ctl(CMD_LDPANC, 2'b00, 1'b1, 5'b11111, 1'b0, 1'b0);
    run_ctl(CMD_LDPANC, 2'b01, 1'b1, 5'b11111, 1'b0, 1'b0);
    run_ctl(CMD_LDPANC, 2'b11, 1'b1, 5'b11111, 1'b0, 1'b0);
    report_test("ctl_cmds", start_errs);
  endtask

  task automatic test_flags();
    int start_errs;
    logic [IDB_W-1:0] d_emcl;
    logic [IDB_W-1:0] d_rst;
    start_errs = err_count;
    d_emcl = rand_idb();
    d_rst  = rand_idb();
    issue(CMD_SIOC, rand_mod(), d_emcl);
    check_value(emcl_n, !d_emcl[IDB_EMCL_BIT], "emcl load");
    issue(CMD_RESET, rand_mod(), d_rst);
    check_value(reset, d_rst[IDB_RESET_BIT], "reset load");
    check_value(emcl_n, !d_emcl[IDB_EMCL_BIT], "emcl hold over reset load");
    // Other commands and lcs low leave both flags
    issue(CMD_START, rand_mod(), rand_idb());
    issue(CMD_READ, rand_mod(), rand_idb());
    cscomm = CMD_SIOC;
    idb    = ~d_emcl;
    next_cycle();
    check_value({emcl_n, reset}, {!d_emcl[IDB_EMCL_BIT], d_rst[IDB_RESET_BIT]}, "flags hold");
    d_emcl[IDB_EMCL_BIT] = !d_emcl[IDB_EMCL_BIT];
    issue(CMD_SIOC, rand_mod(), d_emcl);
    check_value(emcl_n, !d_emcl[IDB_EMCL_BIT], "emcl second load");
    d_rst[IDB_RESET_BIT] = !d_rst[IDB_RESET_BIT];
    issue(CMD_RESET, rand_mod(), d_rst);
    check_value(reset, d_rst[IDB_RESET_BIT], "reset second load");
    next_cycle();
    report_test("flags", start_errs);
  endtask

  task automatic mem_cycle(input logic [CODE_W-1:0] code, input logic hit_v,
                           input logic shadow_v, input logic brk_v, input logic eorf_v);
    logic is_rd;
    logic is_wr;
    logic exp_ecreq;
    is_rd = (code == CMD_FETCH) || (code == CMD_READ);
    is_wr = (code == CMD_WRITE);
    exp_ecreq = (is_rd && hit_v) || (is_wr && brk_v && !shadow_v && eorf_v);
    if (is_rd) begin
      lhit_model = !hit_v;
    end
    issue(code, rand_mod(), rand_idb());
    hit_n   = hit_v;
    lshadow = shadow_v;
    brk_n   = brk_v;
    eorf_n  = eorf_v;
    next_cycle();
    check_value(ecreq, exp_ecreq,
                $sformatf("ecreq code %0h hit_n %0b shadow %0b brk_n %0b eorf_n %0b",
                          code, hit_v, shadow_v, brk_v, eorf_v));
    check_value(lhit, lhit_model, $sformatf("lhit code %0h hit_n %0b", code, hit_v));
    hit_n   = 1'b1;
    lshadow = 1'b0;
    brk_n   = 1'b1;
    eorf_n  = 1'b1;
    next_cycle();
    check_value(ecreq, 1'b0, "ecreq one cycle");
    check_value(lhit, lhit_model, "lhit hold when idle");
  endtask

  task automatic test_bus_req();
    int start_errs;
    start_errs = err_count;
    mem_cycle(CMD_READ, 1'b1, 1'b0, 1'b1, 1'b1);
    mem_cycle(CMD_FETCH, 1'b0, 1'b0, 1'b1, 1'b1);
    mem_cycle(CMD_WRITE, 1'b1, 1'b0, 1'b1, 1'b1);
    mem_cycle(CMD_WRITE, 1'b1, 1'b0, 1'b0, 1'b1);
    mem_cycle(CMD_WRITE, 1'b1, 1'b1, 1'b1, 1'b1);
    mem_cycle(CMD_WRITE, 1'b1, 1'b0, 1'b1, 1'b0);
    mem_cycle(CMD_READ, 1'b0, 1'b0, 1'b1, 1'b1);
    mem_cycle(CMD_FETCH, 1'b1, 1'b0, 1'b1, 1'b1);
    mem_cycle(CMD_WRITE, 1'b0, 1'b0, 1'b1, 1'b1);
    mem_cycle(CMD_READ, 1'b1, 1'b1, 1'b0, 1'b0);
    report_test("bus_req", start_errs);
  endtask

  task automatic test_panel_gating();
    int start_errs;
    start_errs = err_count;
    run_ctl(CMD_LDPANC, MOD_LDPANC, 1'b1, 5'b11111, 1'b1, 1'b0);
    run_ctl(CMD_LDPANC, MOD_LDPANC, 1'b0, 5'b11111, 1'b0, 1'b0);
    run_ctl(CMD_EMPID, rand_mod(), 1'b1, 5'b11111, 1'b0, 1'b1);
    run_ctl(CMD_EMPID, rand_mod(), 1'b0, 5'b11111, 1'b0, 1'b0);
    report_test("panel_gating", start_errs);
  endtask

  // Watchdog
  initial begin
    #((NUM_TESTS * 40 + 100) * 10);
    $display("Simulation timed out before all tests finished");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    seed_ret    = $urandom(98);
    clk         = 1'b0;
    rst_n       = 1'b0;
    lcs         = 1'b0;
    cscomm      = '0;
    csmis       = '0;
    idb         = '0;
    hit_n       = 1'b1;
    lshadow     = 1'b0;
    brk_n       = 1'b1;
    eorf_n      = 1'b1;
    err_count   = 0;
    check_count = 0;
    lhit_model  = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_idle();
    test_mem_cmds();
    test_ctl_cmds();
    test_flags();
    test_bus_req();
    test_panel_gating();
    $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== dga_decode.sv ====
// Decode gate array command decoder, top level
// Memory and control decoders side by side, then the bus request stage

`timescale 1ns/1ns

module dga_decode (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           lcs,
  input  logic [dga_cmd_pkg::CODE_W-1:0] cscomm,
  input  logic [dga_cmd_pkg::MOD_W-1:0]  csmis,
  input  logic [dga_idb_pkg::IDB_W-1:0]  idb,
  input  logic                           hit_n,
  input  logic                           lshadow,
  input  logic                           brk_n,
  input  logic                           eorf_n,
  output logic                           mreq,
  output logic                           fetch,
  output logic                           write,
  output logic                           start_n,
  output logic                           sstop_n,
  output logic                           clrti_n,
  output logic                           sioc_n,
  output logic                           wchim_n,
  output logic                           emcl_n,
  output logic                           reset,
  output logic                           ecreq,
  output logic                           lhit,
  output logic                           ldpanc_n,
  output logic                           empid_n
);

  // Panel pulses between decoder and gating stage
  logic ldpanc;
  logic empid;

  mem_cmd_decode u_mem (
    .clk    (clk),
    .rst_n  (rst_n),
    .lcs    (lcs),
    .cscomm (cscomm),
    .mreq   (mreq),
    .fetch  (fetch),
    .write  (write)
  );

  ctl_cmd_decode u_ctl (
    .clk     (clk),
    .rst_n   (rst_n),
    .lcs     (lcs),
    .cscomm  (cscomm),
    .csmis   (csmis),
    .idb     (idb),
    .start_n (start_n),
    .sstop_n (sstop_n),
    .clrti_n (clrti_n),
    .sioc_n  (sioc_n),
    .wchim_n (wchim_n),
    .emcl_n  (emcl_n),
    .reset   (reset),
    .ldpanc  (ldpanc),
    .empid   (empid)
  );

  bus_req_ctrl u_req (
    .clk      (clk),
    .rst_n    (rst_n),
    .mreq     (mreq),
    .fetch    (fetch),
    .write    (write),
    .ldpanc   (ldpanc),
    .empid    (empid),
    .hit_n    (hit_n),
    .lshadow  (lshadow),
    .brk_n    (brk_n),
    .eorf_n   (eorf_n),
    .ecreq    (ecreq),
    .lhit     (lhit),
    .ldpanc_n (ldpanc_n),
    .empid_n  (empid_n)
  );

endmodule

// ==== bus_req_ctrl.sv ====
// External cycle request and latched cache hit
// Error gating of the ldpanc and empid panel strobes

`timescale 1ns/1ns

module bus_req_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic mreq,
  input  logic fetch,
  input  logic write,
  input  logic ldpanc,
  input  logic empid,
  input  logic hit_n,
  input  logic lshadow,
  input  logic brk_n,
  input  logic eorf_n,
  output logic ecreq,
  output logic lhit,
  output logic ldpanc_n,
  output logic empid_n
);

  logic rd_cycle;
  logic rd_miss;
  logic wr_req;

  // Read or fetch, both look up the cache
  assign rd_cycle = (mreq & ~write) | fetch;

  // Cache miss on a read or fetch goes out to the bus
  assign rd_miss = rd_cycle & hit_n;

  // Writes go out unless stopped by break, shadow or error
  assign wr_req = write & brk_n & ~lshadow & eorf_n;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ecreq <= 1'b0;
      lhit  <= 1'b0;
    end else begin
      ecreq <= rd_miss | wr_req;
      // Hit result is kept across writes and idle cycles
      if (rd_cycle) begin
        lhit <= ~hit_n;
      end
    end
  end

  // Panel strobes suppressed while an error is flagged
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ldpanc_n <= 1'b1;
      empid_n  <= 1'b1;
    end else begin
      ldpanc_n <= ~(ldpanc & eorf_n);
      empid_n  <= ~(empid & eorf_n);
    end
  end

endmodule

// ==== ctl_cmd_decode.sv ====
// Control command decoder
// Registered panel and control strobes, ldpanc and empid pulses
// emcl and reset flags loaded from the internal databus

`timescale 1ns/1ns

module ctl_cmd_decode (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           lcs,
  input  logic [dga_cmd_pkg::CODE_W-1:0] cscomm,
  input  logic [dga_cmd_pkg::MOD_W-1:0]  csmis,
  input  logic [dga_idb_pkg::IDB_W-1:0]  idb,
  output logic                           start_n,
  output logic                           sstop_n,
  output logic                           clrti_n,
  output logic                           sioc_n,
  output logic                           wchim_n,
  output logic                           emcl_n,
  output logic                           reset,
  output logic                           ldpanc,
  output logic                           empid
);

  import dga_cmd_pkg::*;
  import dga_idb_pkg::*;

  logic start_d;
  logic sstop_d;
  logic clrti_d;
  logic sioc_d;
  logic wchim_d;
  logic ldpanc_d;
  logic empid_d;
  logic reset_ld;
  logic emcl;

  // Decode in the strobe cycle, active high internally
  always_comb begin
    start_d  = 1'b0;
    sstop_d  = 1'b0;
    clrti_d  = 1'b0;
    sioc_d   = 1'b0;
    wchim_d  = 1'b0;
    ldpanc_d = 1'b0;
    empid_d  = 1'b0;
    reset_ld = 1'b0;
    if (lcs) begin
      case (cscomm)
        CMD_START:  start_d  = 1'b1;
        CMD_SSTOP:  sstop_d  = 1'b1;
        CMD_CLRTI:  clrti_d  = 1'b1;
        CMD_SIOC:   sioc_d   = 1'b1;
        CMD_RESET:  reset_ld = 1'b1;
        CMD_EMPID:  empid_d  = 1'b1;
        // These two need the matching modifier
        CMD_LDPANC: ldpanc_d = (csmis == MOD_LDPANC);
        CMD_WCHIM:  wchim_d  = (csmis == MOD_WCHIM);
        default: ;
      endcase
    end
  end

  // Strobes last one cycle after the command
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_n <= 1'b1;
      sstop_n <= 1'b1;
      clrti_n <= 1'b1;
      sioc_n  <= 1'b1;
      wchim_n <= 1'b1;
      ldpanc  <= 1'b0;
      empid   <= 1'b0;
    end else begin
      start_n <= ~start_d;
      sstop_n <= ~sstop_d;
      clrti_n <= ~clrti_d;
      sioc_n  <= ~sioc_d;
      wchim_n <= ~wchim_d;
      ldpanc  <= ldpanc_d;
      empid   <= empid_d;
    end
  end

  // Flags hold until their command loads them again
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      emcl  <= 1'b0;
      reset <= 1'b0;
    end else begin
      if (sioc_d) begin
        emcl <= idb[IDB_EMCL_BIT];
      end
      if (reset_ld) begin
        reset <= idb[IDB_RESET_BIT];
      end
    end
  end

  assign emcl_n = ~emcl;

endmodule

// ==== mem_cmd_decode.sv ====
// Memory command decoder
// Registers the mreq, fetch and write cycle levels

`timescale 1ns/1ns

module mem_cmd_decode (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           lcs,
  input  logic [dga_cmd_pkg::CODE_W-1:0] cscomm,
  output logic                           mreq,
  output logic                           fetch,
  output logic                           write
);

  import dga_cmd_pkg::*;

  logic mreq_d;
  logic fetch_d;
  logic write_d;

  // Only the three memory codes start a cycle
  always_comb begin
    mreq_d  = 1'b0;
    fetch_d = 1'b0;
    write_d = 1'b0;
    if (lcs) begin
      case (cscomm)
        CMD_FETCH: begin
          mreq_d  = 1'b1;
          fetch_d = 1'b1;
        end
        CMD_READ: begin
          mreq_d = 1'b1;
        end
        CMD_WRITE: begin
          mreq_d  = 1'b1;
          write_d = 1'b1;
        end
        // Other codes, memory or control, start nothing
        default: ;
      endcase
    end
  end

  // One-cycle levels, cleared whenever lcs was low
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mreq  <= 1'b0;
      fetch <= 1'b0;
      write <= 1'b0;
    end else begin
      mreq  <= mreq_d;
      fetch <= fetch_d;
      write <= write_d;
    end
  end

endmodule

// ==== dga_idb_pkg.sv ====
// Internal databus width
// Databus bit positions feeding the emcl and reset flags

package dga_idb_pkg;

  // Width of the idb input
  localparam int IDB_W = 8;

  // Bit loaded into emcl by a SIOC command
  localparam int IDB_EMCL_BIT = 5;

  // Bit loaded into the reset flag by a RESET command
  localparam int IDB_RESET_BIT = 7;

endpackage

// ==== dga_cmd_pkg.sv ====
// Command field widths for the internal databus command
// Named command codes and modifier values of the decode gate array

package dga_cmd_pkg;

  // Command code and modifier widths
  localparam int CODE_W = 5;
  localparam int MOD_W  = 2;

  // Memory commands, code bit 4 set
  // Instruction fetch
  localparam logic [CODE_W-1:0] CMD_FETCH  = 5'h14;
  // Data read
  localparam logic [CODE_W-1:0] CMD_READ   = 5'h12;
  // Data write
  localparam logic [CODE_W-1:0] CMD_WRITE  = 5'h18;

  // Control commands, code bit 4 clear
  // Start
  localparam logic [CODE_W-1:0] CMD_START  = 5'h0B;
  // Stop
  localparam logic [CODE_W-1:0] CMD_SSTOP  = 5'h0F;
  // Clear interrupt timer
  localparam logic [CODE_W-1:0] CMD_CLRTI  = 5'h0D;
  // Serial I/O control, also loads emcl
  localparam logic [CODE_W-1:0] CMD_SIOC   = 5'h07;
  // Loads the reset flag
  localparam logic [CODE_W-1:0] CMD_RESET  = 5'h02;
  // Empty panel interrupt
  localparam logic [CODE_W-1:0] CMD_EMPID  = 5'h0A;
  // Load panel control
  localparam logic [CODE_W-1:0] CMD_LDPANC = 5'h06;
  // Write channel image
  localparam logic [CODE_W-1:0] CMD_WCHIM  = 5'h01;

  // Modifier values required by the qualified commands
  localparam logic [MOD_W-1:0] MOD_LDPANC = 2'b10;
  localparam logic [MOD_W-1:0] MOD_WCHIM  = 2'b00;

endpackage
